// File: rtl/bridge_config.svh
`ifndef BRIDGE_CONFIG_SVH
`define BRIDGE_CONFIG_SVH

// wishbone side
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// sdram request port, addressed in halfwords
`define SDR_DATA_W 16
`define SDR_ADDR_W 24

// address map
`define SDR_REGION_BIT 27
`define IO_REGION_TAG 4'h1
`define IO_TRACE_OFS 12'h000
`define IO_BGCOL_OFS 12'h004

// rdy is not looked at for this many cycles after a request starts
`define SDR_SETTLE_CYCLES 2
`define SDR_TIMEOUT_CYCLES 64

`define BGCOL_W 24

`endif

// File: rtl/bridge_pkg.sv
package bridge_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HALF_LO,
        ST_HALF_HI,
        ST_RESP,
        ST_ERROR
    } fsm_state_e;

    // target of a wishbone access
    typedef enum logic [1:0] {
        REGION_SDRAM,
        REGION_IO,
        REGION_NONE
    } region_e;

    // io register picked by the address offset
    typedef enum logic [1:0] {
        IO_REG_TRACE,
        IO_REG_BGCOL,
        IO_REG_INVALID
    } io_reg_e;

endpackage

// File: rtl/sdr_seq_if.sv
`include "bridge_config.svh"

interface sdr_seq_if;

    // one-cycle start of a halfword transfer
    logic                   issue;
    logic                   is_wr;
    logic                   half_hi;
    // 32-bit word address, the port appends the half select
    logic [`SDR_ADDR_W-2:0] word_addr;

    // request still outstanding on the sdram side
    logic                   busy;
    // halfword accepted, one cycle
    logic                   done;

    modport fsm (
        output issue, is_wr, half_hi, word_addr,
        input  busy, done
    );

    modport port (
        input  issue, is_wr, half_hi, word_addr,
        output busy, done
    );

endinterface

// File: rtl/bridge_fsm.sv
`include "bridge_config.svh"

module bridge_fsm
    import bridge_pkg::*;
(
    input  logic                         clk_sys,
    input  logic                         reset_n,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [`BRIDGE_ADDR_W-1:0]    wb_adr_i,
    input  logic [`BRIDGE_DATA_W/8-1:0]  wb_sel_i,
    input  logic                         settled_i,
    input  logic                         expired_i,
    input  logic                         io_bad_i,
    output logic                         wb_ack_o,
    output logic                         wb_err_o,
    output logic                         io_wr_o,
    output logic                         io_rd_o,
    output logic                         timer_start_o,
    sdr_seq_if.fsm                       seq
);

    fsm_state_e state;
    region_e    region;
    logic       req;
    logic       need_lo;
    logic       need_hi;
    logic       sel_ok;
    logic       sdr_free;
    logic       issue_q;

    // only a fresh access in idle counts, the master holds stb through the response
    assign req = wb_cyc_i && wb_stb_i && (state == ST_IDLE);

    always_comb begin
        if (wb_adr_i[`SDR_REGION_BIT]) begin
            region = REGION_SDRAM;
        end else if (wb_adr_i[`SDR_REGION_BIT:`SDR_REGION_BIT-3] == `IO_REGION_TAG) begin
            region = REGION_IO;
        end else begin
            region = REGION_NONE;
        end
    end

    // halfword plan, reads always fetch the whole word
    always_comb begin
        need_lo = 1'b1;
        need_hi = 1'b1;
        sel_ok  = 1'b1;
        if (wb_we_i) begin
            case (wb_sel_i)
                4'b1111: sel_ok = 1'b1;
                4'b0011: need_hi = 1'b0;
                4'b1100: need_lo = 1'b0;
                default: sel_ok = 1'b0;
            endcase
        end
    end

    // port and timer both idle before a new transfer starts
    assign sdr_free = !seq.busy && !settled_i;

    assign io_wr_o = req && (region == REGION_IO) && wb_we_i;
    assign io_rd_o = req && (region == REGION_IO) && !wb_we_i;

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            state   <= ST_IDLE;
            issue_q <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        case (region)
                            REGION_IO: begin
                                state <= io_bad_i ? ST_ERROR : ST_RESP;
                            end
                            REGION_SDRAM: begin
                                if (!sel_ok) begin
                                    state <= ST_ERROR;
                                end else if (sdr_free) begin
                                    issue_q <= 1'b1;
                                    state   <= need_lo ? ST_HALF_LO : ST_HALF_HI;
                                end
                            end
                            default: state <= ST_ERROR;
                        endcase
                    end
                end
                ST_HALF_LO: begin
                    if (seq.done) begin
                        if (need_hi) begin
                            issue_q <= 1'b1;
                            state   <= ST_HALF_HI;
                        end else begin
                            state <= ST_RESP;
                        end
                    end else if (expired_i) begin
                        state <= ST_ERROR;
                    end
                end
                ST_HALF_HI: begin
                    if (seq.done) begin
                        state <= ST_RESP;
                    end else if (expired_i) begin
                        state <= ST_ERROR;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // response states last exactly one cycle
    assign wb_ack_o = (state == ST_RESP);
    assign wb_err_o = (state == ST_ERROR);

    assign seq.issue     = issue_q;
    assign seq.is_wr     = wb_we_i;
    assign seq.half_hi   = (state == ST_HALF_HI);
    assign seq.word_addr = wb_adr_i[`SDR_ADDR_W:2];
    assign timer_start_o = issue_q;

endmodule

// File: rtl/wait_timer.sv
`include "bridge_config.svh"

module wait_timer (
    input  logic clk_sys,
    input  logic reset_n,
    input  logic start_i,
    input  logic done_i,
    output logic settled_o,
    output logic expired_o
);

    localparam int CNT_W = $clog2(`SDR_TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic             active;

    // cnt holds the number of the current request cycle, starting at 1
    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start_i) begin
            active <= 1'b1;
            cnt    <= CNT_W'(1);
        end else if (active) begin
            if (done_i || expired_o) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign expired_o = active && (cnt == CNT_W'(`SDR_TIMEOUT_CYCLES));

    // response window closes in the expiry cycle so a late rdy is never taken
    assign settled_o = active && (cnt > CNT_W'(`SDR_SETTLE_CYCLES)) && !expired_o;

endmodule

// File: rtl/sdram_port.sv
`include "bridge_config.svh"

module sdram_port (
    input  logic                      clk_sys,
    input  logic                      reset_n,
    input  logic [`BRIDGE_DATA_W-1:0] wb_dat_i,
    input  logic [`SDR_DATA_W-1:0]    sdr_rdata_i,
    input  logic                      sdr_rdy_i,
    input  logic                      settled_i,
    output logic                      sdr_rd_o,
    output logic                      sdr_wr_o,
    output logic [`SDR_ADDR_W-1:0]    sdr_addr_o,
    output logic [`SDR_DATA_W-1:0]    sdr_wdata_o,
    output logic [`BRIDGE_DATA_W-1:0] rdata_o,
    sdr_seq_if.port                   seq
);

    logic settled_q;
    logic accept;
    logic abort;

    assign seq.busy = sdr_rd_o || sdr_wr_o;

    // rdy only counts once the settle wait is over
    assign accept   = seq.busy && settled_i && sdr_rdy_i;
    assign seq.done = accept;

    // window closing while still waiting means the watchdog fired
    assign abort = seq.busy && settled_q && !settled_i;

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            sdr_rd_o  <= 1'b0;
            sdr_wr_o  <= 1'b0;
            settled_q <= 1'b0;
        end else begin
            settled_q <= settled_i;
            if (seq.issue) begin
                sdr_rd_o <= !seq.is_wr;
                sdr_wr_o <= seq.is_wr;
            end else if (accept || abort) begin
                sdr_rd_o <= 1'b0;
                sdr_wr_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (seq.issue) begin
            sdr_addr_o <= {seq.word_addr, seq.half_hi};
            if (seq.half_hi) begin
                sdr_wdata_o <= wb_dat_i[`BRIDGE_DATA_W-1:`SDR_DATA_W];
            end else begin
                sdr_wdata_o <= wb_dat_i[`SDR_DATA_W-1:0];
            end
        end
        // odd halfword address fills the upper half of the word
        if (accept && sdr_rd_o) begin
            if (sdr_addr_o[0]) begin
                rdata_o[`BRIDGE_DATA_W-1:`SDR_DATA_W] <= sdr_rdata_i;
            end else begin
                rdata_o[`SDR_DATA_W-1:0] <= sdr_rdata_i;
            end
        end
    end

endmodule

// File: rtl/io_regs.sv
`include "bridge_config.svh"

module io_regs
    import bridge_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      reset_n,
    input  logic                      io_wr_i,
    input  logic                      io_rd_i,
    input  logic [`BRIDGE_ADDR_W-1:0] wb_adr_i,
    input  logic [`BRIDGE_DATA_W-1:0] wb_dat_i,
    output logic [`BRIDGE_DATA_W-1:0] io_rdata_o,
    output logic                      io_bad_o,
    output logic [7:0]                trace_data_o,
    output logic                      trace_valid_o,
    output logic [`BGCOL_W-1:0]       bg_color_o
);

    io_reg_e io_reg;

    always_comb begin
        case (wb_adr_i[11:0])
            `IO_TRACE_OFS: io_reg = IO_REG_TRACE;
            `IO_BGCOL_OFS: io_reg = IO_REG_BGCOL;
            default:       io_reg = IO_REG_INVALID;
        endcase
    end

    assign io_bad_o = (io_reg == IO_REG_INVALID);

    always_ff @(posedge clk_sys) begin
        if (!reset_n) begin
            trace_valid_o <= 1'b0;
            bg_color_o    <= '0;
        end else begin
            trace_valid_o <= io_wr_i && (io_reg == IO_REG_TRACE);
            // a zero write leaves the colour alone
            if (io_wr_i && (io_reg == IO_REG_BGCOL) && (wb_dat_i != '0)) begin
                bg_color_o <= wb_dat_i[`BGCOL_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (io_wr_i && (io_reg == IO_REG_TRACE)) begin
            trace_data_o <= wb_dat_i[7:0];
        end
        // read data is ready in the ack cycle
        if (io_rd_i) begin
            case (io_reg)
                IO_REG_TRACE: io_rdata_o <= {{(`BRIDGE_DATA_W-8){1'b0}}, trace_data_o};
                IO_REG_BGCOL: io_rdata_o <= {{(`BRIDGE_DATA_W-`BGCOL_W){1'b0}}, bg_color_o};
                default:      io_rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: rtl/mem_bridge_top.sv
`include "bridge_config.svh"

module mem_bridge_top (
    input  logic                         clk_sys,
    input  logic                         reset_n,
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [`BRIDGE_ADDR_W-1:0]    wb_adr_i,
    input  logic [`BRIDGE_DATA_W-1:0]    wb_dat_i,
    input  logic [`BRIDGE_DATA_W/8-1:0]  wb_sel_i,
    output logic [`BRIDGE_DATA_W-1:0]    wb_dat_o,
    output logic                         wb_ack_o,
    output logic                         wb_err_o,
    output logic                         sdr_rd_o,
    output logic                         sdr_wr_o,
    output logic [`SDR_ADDR_W-1:0]       sdr_addr_o,
    output logic [`SDR_DATA_W-1:0]       sdr_wdata_o,
    input  logic [`SDR_DATA_W-1:0]       sdr_rdata_i,
    input  logic                         sdr_rdy_i,
    output logic [7:0]                   trace_data_o,
    output logic                         trace_valid_o,
    output logic [`BGCOL_W-1:0]          bg_color_o
);

    logic                      settled;
    logic                      expired;
    logic                      timer_start;
    logic                      io_wr;
    logic                      io_rd;
    logic                      io_bad;
    logic [`BRIDGE_DATA_W-1:0] io_rdata;
    logic [`BRIDGE_DATA_W-1:0] sdr_word;

    sdr_seq_if seq_bus ();

    bridge_fsm u_fsm (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .settled_i     (settled),
        .expired_i     (expired),
        .io_bad_i      (io_bad),
        .wb_ack_o      (wb_ack_o),
        .wb_err_o      (wb_err_o),
        .io_wr_o       (io_wr),
        .io_rd_o       (io_rd),
        .timer_start_o (timer_start),
        .seq           (seq_bus.fsm)
    );

    wait_timer u_timer (
        .clk_sys   (clk_sys),
        .reset_n   (reset_n),
        .start_i   (timer_start),
        .done_i    (seq_bus.done),
        .settled_o (settled),
        .expired_o (expired)
    );

    sdram_port u_sdram_port (
        .clk_sys     (clk_sys),
        .reset_n     (reset_n),
        .wb_dat_i    (wb_dat_i),
        .sdr_rdata_i (sdr_rdata_i),
        .sdr_rdy_i   (sdr_rdy_i),
        .settled_i   (settled),
        .sdr_rd_o    (sdr_rd_o),
        .sdr_wr_o    (sdr_wr_o),
        .sdr_addr_o  (sdr_addr_o),
        .sdr_wdata_o (sdr_wdata_o),
        .rdata_o     (sdr_word),
        .seq         (seq_bus.port)
    );

    io_regs u_io_regs (
        .clk_sys       (clk_sys),
        .reset_n       (reset_n),
        .io_wr_i       (io_wr),
        .io_rd_i       (io_rd),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .io_rdata_o    (io_rdata),
        .io_bad_o      (io_bad),
        .trace_data_o  (trace_data_o),
        .trace_valid_o (trace_valid_o),
        .bg_color_o    (bg_color_o)
    );

    // address is held by the master, so it still picks the source in the ack cycle
    assign wb_dat_o = wb_adr_i[`SDR_REGION_BIT] ? sdr_word : io_rdata;

endmodule

// File: sim/bridge_props.sv
module bridge_props (
    input logic clk_sys,
    input logic reset_n,
    input logic wb_stb_i,
    input logic wb_ack_o,
    input logic wb_err_o,
    input logic sdr_rd_o,
    input logic sdr_wr_o,
    input logic trace_valid_o
);

    int fail_count = 0;

    ack_err_excl: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !(wb_ack_o && wb_err_o))
        else begin
            fail_count++;
            $error("ack and err high in the same cycle");
        end

    rd_wr_excl: assert property (@(posedge clk_sys) disable iff (!reset_n)
        !(sdr_rd_o && sdr_wr_o))
        else begin
            fail_count++;
            $error("sdram rd and wr high in the same cycle");
        end

    // ack belongs to a strobed access
    ack_with_stb: assert property (@(posedge clk_sys) disable iff (!reset_n)
        wb_ack_o |-> wb_stb_i)
        else begin
            fail_count++;
            $error("ack without stb");
        end

    trace_one_cycle: assert property (@(posedge clk_sys) disable iff (!reset_n)
        trace_valid_o |=> !trace_valid_o)
        else begin
            fail_count++;
            $error("trace_valid_o longer than one cycle");
        end

endmodule

bind mem_bridge_top bridge_props u_props (
    .clk_sys       (clk_sys),
    .reset_n       (reset_n),
    .wb_stb_i      (wb_stb_i),
    .wb_ack_o      (wb_ack_o),
    .wb_err_o      (wb_err_o),
    .sdr_rd_o      (sdr_rd_o),
    .sdr_wr_o      (sdr_wr_o),
    .trace_valid_o (trace_valid_o)
);

// File: sim/bridge_monitor.sv
`include "bridge_config.svh"

module bridge_monitor (
    input  logic                         clk_sys,
    input  logic                         reset_n,
    input  logic                         wb_we_i,
    input  logic [`BRIDGE_ADDR_W-1:0]    wb_adr_i,
    input  logic [`BRIDGE_DATA_W-1:0]    wb_dat_i,
    input  logic [`BRIDGE_DATA_W/8-1:0]  wb_sel_i,
    input  logic [`BRIDGE_DATA_W-1:0]    wb_dat_o,
    input  logic                         wb_ack_o,
    input  logic                         wb_err_o,
    input  logic                         sdr_rd_o,
    input  logic                         sdr_wr_o,
    input  logic [`SDR_ADDR_W-1:0]       sdr_addr_o,
    input  logic [`SDR_DATA_W-1:0]       sdr_wdata_o,
    input  logic [7:0]                   trace_data_o,
    input  logic                         trace_valid_o,
    input  logic [`BGCOL_W-1:0]          bg_color_o,
    input  logic                         acc_start_i,
    input  logic                         acc_end_i,
    input  logic [`BRIDGE_DATA_W-1:0]    exp_data_i,
    input  logic                         exp_err_i,
    input  int                           exp_halves_i,
    output int                           err_count_o,
    output int                           check_count_o
);

    int                     errors = 0;
    int                     checks = 0;
    int                     req_count = 0;
    int                     resp_count = 0;
    int                     trace_count = 0;
    int                     exp_trace = 0;
    logic                   in_acc = 1'b0;
    logic                   req_q = 1'b0;
    logic                   reset_seen = 1'b0;
    logic                   half;
    logic                   is_io;
    logic [`SDR_ADDR_W-1:0] exp_addr;
    logic [`BGCOL_W-1:0]    bg_model = '0;

    assign err_count_o   = errors;
    assign check_count_o = checks;
    assign is_io = !wb_adr_i[`SDR_REGION_BIT] &&
                   (wb_adr_i[`SDR_REGION_BIT:`SDR_REGION_BIT-3] == `IO_REGION_TAG);

    task automatic expect_true(input bit ok, input string msg);
        checks++;
        if (!ok) begin
            errors++;
            $display("ERROR @ %0t: %s", $time, msg);
        end
    endtask

    always @(posedge clk_sys) begin
        if (!reset_n) begin
            reset_seen <= 1'b1;
        end
    end

    // sampled mid-cycle, where dut outputs have settled
    always @(negedge clk_sys) begin
        if (!reset_n) begin
            if (reset_seen) begin
                expect_true(!wb_ack_o && !wb_err_o && !sdr_rd_o && !sdr_wr_o &&
                            !trace_valid_o && (bg_color_o == '0), "outputs not idle in reset");
            end
        end else begin
            if (acc_start_i) begin
                in_acc      = 1'b1;
                req_count   = 0;
                resp_count  = 0;
                trace_count = 0;
                exp_trace   = 0;
            end
            // full words go low half first, single halves follow the select
            if ((sdr_rd_o || sdr_wr_o) && !req_q) begin
                half     = (exp_halves_i == 2) ? (req_count == 1) : (wb_sel_i == 4'b1100);
                exp_addr = {wb_adr_i[`SDR_ADDR_W:2], half};
                expect_true(in_acc, "sdram request outside an access");
                expect_true(sdr_addr_o == exp_addr,
                            $sformatf("halfword address %h, expected %h", sdr_addr_o, exp_addr));
                expect_true(sdr_wr_o == wb_we_i, "sdram request direction does not match");
                if (sdr_wr_o) begin
                    expect_true(sdr_wdata_o == (half ? wb_dat_i[31:16] : wb_dat_i[15:0]),
                                $sformatf("halfword write data %h", sdr_wdata_o));
                end
                req_count++;
            end
            req_q = sdr_rd_o || sdr_wr_o;
            if (wb_ack_o || wb_err_o) begin
                resp_count++;
                expect_true(in_acc && (resp_count == 1), "response outside an access");
                expect_true(wb_err_o == exp_err_i,
                            $sformatf("err %b ack %b, expected err %b", wb_err_o, wb_ack_o,
                                      exp_err_i));
                if (wb_ack_o && !wb_we_i) begin
                    expect_true(wb_dat_o == exp_data_i,
                                $sformatf("read data %h, expected %h", wb_dat_o, exp_data_i));
                end
                if (wb_ack_o && wb_we_i && is_io && (wb_adr_i[11:0] == `IO_TRACE_OFS)) begin
                    exp_trace = 1;
                end
                // zero writes never reach the colour
                if (wb_ack_o && wb_we_i && is_io && (wb_adr_i[11:0] == `IO_BGCOL_OFS) &&
                    (wb_dat_i != '0)) begin
                    bg_model = wb_dat_i[`BGCOL_W-1:0];
                end
            end
            if (trace_valid_o) begin
                trace_count++;
                expect_true(trace_data_o == wb_dat_i[7:0],
                            $sformatf("trace byte %h, expected %h", trace_data_o, wb_dat_i[7:0]));
            end
            if (acc_end_i && in_acc) begin
                in_acc = 1'b0;
                expect_true(resp_count == 1, "access ended without exactly one response");
                expect_true(req_count == exp_halves_i,
                            $sformatf("%0d sdram requests, expected %0d", req_count,
                                      exp_halves_i));
                expect_true(trace_count == exp_trace,
                            $sformatf("%0d trace pulses, expected %0d", trace_count, exp_trace));
                expect_true(bg_color_o == bg_model,
                            $sformatf("bg_color_o %h, expected %h", bg_color_o, bg_model));
            end
        end
    end

endmodule

// File: sim/tb_mem_bridge.sv
`include "bridge_config.svh"

module tb_mem_bridge;

    localparam int WAIT_LIMIT = 200;

    logic                         clk_sys;
    logic                         reset_n;
    logic                         wb_cyc_i;
    logic                         wb_stb_i;
    logic                         wb_we_i;
    logic [`BRIDGE_ADDR_W-1:0]    wb_adr_i;
    logic [`BRIDGE_DATA_W-1:0]    wb_dat_i;
    logic [`BRIDGE_DATA_W/8-1:0]  wb_sel_i;
    logic [`BRIDGE_DATA_W-1:0]    wb_dat_o;
    logic                         wb_ack_o;
    logic                         wb_err_o;
    logic                         sdr_rd_o;
    logic                         sdr_wr_o;
    logic [`SDR_ADDR_W-1:0]       sdr_addr_o;
    logic [`SDR_DATA_W-1:0]       sdr_wdata_o;
    logic [`SDR_DATA_W-1:0]       sdr_rdata_i;
    logic                         sdr_rdy_i;
    logic [7:0]                   trace_data_o;
    logic                         trace_valid_o;
    logic [`BGCOL_W-1:0]          bg_color_o;

    // expectations handed to the monitor
    logic                         acc_start_i;
    logic                         acc_end_i;
    logic [`BRIDGE_DATA_W-1:0]    exp_data_i;
    logic                         exp_err_i;
    int                           exp_halves_i;
    int                           err_count_o;
    int                           check_count_o;

    logic                         hold_answer;
    logic [`SDR_DATA_W-1:0]       sdr_mem [logic [`SDR_ADDR_W-1:0]];
    int                           tb_errors;
    bit                           timed_out;
    int                           fd;
    string                        line;
    byte                          op;
    logic [31:0]                  adr;
    logic [31:0]                  dat;
    logic [3:0]                   sel;
    logic [31:0]                  xdata;
    int                           xerr;
    int                           xhalves;

    mem_bridge_top UUT (.*);

    bridge_monitor u_monitor (.*);

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    // unwritten halfwords read back a pattern of their full address
    function automatic logic [15:0] read_half(input logic [`SDR_ADDR_W-1:0] addr);
        if (sdr_mem.exists(addr)) begin
            return sdr_mem[addr];
        end
        return addr[15:0] ^ {addr[23:16], addr[23:16]};
    endfunction

    // sdram model, holds rdy from 3 to 10 cycles after the request until it drops
    initial begin
        int  wait_left;
        bit  pending;
        void'($urandom(32'hc5e2));
        sdr_rdy_i   = 1'b0;
        sdr_rdata_i = '0;
        pending     = 1'b0;
        wait_left   = 0;
        forever begin
            @(posedge clk_sys);
            #2;
            if (!(sdr_rd_o || sdr_wr_o)) begin
                sdr_rdy_i = 1'b0;
                pending   = 1'b0;
            end else if (!pending) begin
                pending   = 1'b1;
                wait_left = 3 + ($urandom % 8);
            end else if (wait_left > 1) begin
                wait_left = wait_left - 1;
            end else if (!hold_answer && !sdr_rdy_i) begin
                sdr_rdy_i = 1'b1;
                if (sdr_wr_o) begin
                    sdr_mem[sdr_addr_o] = sdr_wdata_o;
                end else begin
                    sdr_rdata_i = read_half(sdr_addr_o);
                end
            end
        end
    end

    task automatic run_access(input byte op_c, input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] s, input logic [31:0] xd, input int xe,
                              input int xh, output bit expired);
        int waited;
        bit seen;
        @(posedge clk_sys);
        #2;
        acc_end_i    = 1'b0;
        wb_cyc_i     = 1'b1;
        wb_stb_i     = 1'b1;
        wb_we_i      = (op_c == "W");
        wb_adr_i     = a;
        wb_dat_i     = d;
        wb_sel_i     = s;
        hold_answer  = (op_c == "H");
        exp_data_i   = xd;
        exp_err_i    = (xe != 0);
        exp_halves_i = xh;
        acc_start_i  = 1'b1;
        @(posedge clk_sys);
        #2 acc_start_i = 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && (waited < WAIT_LIMIT)) begin
            @(negedge clk_sys);
            seen   = wb_ack_o || wb_err_o;
            waited = waited + 1;
        end
        expired = !seen;
        if (!seen) begin
            $display("timeout: no ack or err within %0d cycles at address %h", WAIT_LIMIT, a);
        end
        @(posedge clk_sys);
        #2;
        wb_cyc_i    = 1'b0;
        wb_stb_i    = 1'b0;
        hold_answer = 1'b0;
        acc_end_i   = 1'b1;
    endtask

    initial begin
        reset_n      = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        acc_start_i  = 1'b0;
        acc_end_i    = 1'b0;
        exp_data_i   = '0;
        exp_err_i    = 1'b0;
        exp_halves_i = 0;
        hold_answer  = 1'b0;
        tb_errors    = 0;
        timed_out    = 1'b0;
        repeat (2) @(posedge clk_sys);
        #2 reset_n = 1'b1;
        fd = $fopen("sim/bridge_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/bridge_tests.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                void'($fgets(line, fd));
                if ((line.len() > 1) && (line.getc(0) != "#")) begin
                    if ($sscanf(line, "%c %h %h %h %h %d %d", op, adr, dat, sel, xdata, xerr,
                                xhalves) == 7) begin
                        run_access(op, adr, dat, sel, xdata, xerr, xhalves, timed_out);
                    end else begin
                        $display("malformed line in the tests file: %s", line);
                        tb_errors++;
                    end
                end
            end
            $fclose(fd);
        end
        @(posedge clk_sys);
        #2 acc_end_i = 1'b0;
        repeat (3) @(posedge clk_sys);
        if (timed_out) begin
            tb_errors++;
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d, testbench errors: %0d",
                 check_count_o, err_count_o, UUT.u_props.fail_count, tb_errors);
        if ((err_count_o == 0) && (tb_errors == 0) && (UUT.u_props.fail_count == 0) &&
            (check_count_o > 0)) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/bridge_pkg.sv
rtl/sdr_seq_if.sv
rtl/bridge_fsm.sv
rtl/wait_timer.sv
rtl/sdram_port.sv
rtl/io_regs.sv
rtl/mem_bridge_top.sv
sim/bridge_props.sv
sim/bridge_monitor.sv
sim/tb_mem_bridge.sv

// File: Bender.yml
package:
  name: mem_bridge

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bridge_pkg.sv
      - rtl/sdr_seq_if.sv
      - rtl/bridge_fsm.sv
      - rtl/wait_timer.sv
      - rtl/sdram_port.sv
      - rtl/io_regs.sv
      - rtl/mem_bridge_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/bridge_props.sv
      - sim/bridge_monitor.sv
      - sim/tb_mem_bridge.sv

// File: sim/bridge_tests.txt
# op addr data sel exp_data exp_err halfword_requests (first five columns hex)
# op W is a write, R a read, H a read whose sdram answer is held back
W 08000010 12345678 f 00000000 0 2
R 08000010 00000000 f 12345678 0 2
W 08000020 cafef00d f 00000000 0 2
W 08000020 0000beef 3 00000000 0 1
R 08000020 00000000 f cafebeef 0 2
W 08000020 12340000 c 00000000 0 1
R 08000020 00000000 f 1234beef 0 2
R 08000010 00000000 6 12345678 0 2
W 01000000 123456a5 f 00000000 0 0
R 01000000 00000000 f 000000a5 0 0
W 01000004 77336699 f 00000000 0 0
R 01000004 00000000 f 00336699 0 0
W 01000004 00000000 f 00000000 0 0
R 01000004 00000000 f 00336699 0 0
W 00000100 11111111 f 00000000 1 0
R 02000040 00000000 f 00000000 1 0
W 01000008 22222222 f 00000000 1 0
R 01000010 00000000 f 00000000 1 0
W 08000030 33333333 6 00000000 1 0
H 08000040 00000000 f 00000000 1 1
R 08000010 00000000 f 12345678 0 2
W 08000050 a5a55a5a f 00000000 0 2
R 08000050 00000000 f a5a55a5a 0 2
W 0800fffc 0badcafe f 00000000 0 2
R 0800fffc 00000000 f 0badcafe 0 2
